// File: bench/rv32e_subsys_chk.sv
// bound protocol checks for rv32e_subsys; counters assume the host returns credits as single-cycle pulses
`timescale 1ns/10ps
`default_nettype none

module rv32e_subsys_chk
    import rv32e_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic host_req_valid,
    input logic host_req_credit,
    input logic host_rsp_valid,
    input logic host_rsp_credit,
    input logic core_req_valid,
    input logic core_gnt,
    input logic host_take
);

    // requests sent and not yet credited back
    int req_out;
    // response credits the host still holds
    int rsp_avail;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_out   <= 0;
            rsp_avail <= RSP_CREDITS;
        end else begin
            req_out   <= req_out + int'(host_req_valid) - int'(host_req_credit);
            rsp_avail <= rsp_avail + int'(host_rsp_credit) - int'(host_rsp_valid);
        end
    end

    // a credit returned in the same cycle may be reused at once
    req_within_credit: assert property (@(posedge clk) disable iff (rst)
        host_req_valid |-> (req_out < HOST_CREDITS || host_req_credit))
        else $error("host request sent while %0d requests were outstanding", req_out);

    rsp_within_credit: assert property (@(posedge clk) disable iff (rst)
        host_rsp_valid |-> (rsp_avail > 0))
        else $error("host response sent without a response credit");

    // a core kept waiting by the host wins the next cycle
    core_after_host: assert property (@(posedge clk) disable iff (rst)
        $past(host_take && core_req_valid) |-> core_gnt)
        else $error("core not granted after losing to the host");

endmodule

bind rv32e_subsys rv32e_subsys_chk rv32e_subsys_chk_inst (
    .clk             (clk),
    .rst             (rst),
    .host_req_valid  (host_req_valid),
    .host_req_credit (host_req_credit),
    .host_rsp_valid  (host_rsp_valid),
    .host_rsp_credit (host_rsp_credit),
    .core_req_valid  (core_req_valid),
    .core_gnt        (core_gnt),
    .host_take       (host_take)
);

`default_nettype wire

// File: bench/subsys_cases.txt
// columns: op word_address data, all hex; data is the write value or the expected read value
// op 0 write, 1 read and expect, 2 run to halt, 3 expect illegal, 4 end of test (data = id), f end
// test 1: memory round trip
0 c0 12345678
0 c1 9abcdef0
0 c2 ffffffff
0 c3 00000001
1 c0 12345678
1 c1 9abcdef0
1 c2 ffffffff
1 c3 00000001
4 00 00000001
// test 2: request and response credit bursts
0 d0 a5a5a5a5
0 d1 5a5a0000
0 d2 0000ffff
0 d3 80000000
1 d3 80000000
1 d2 0000ffff
1 d1 5a5a0000
1 d0 a5a5a5a5
4 00 00000002
// test 3: ALU program, base x1 = 0x100 (word 40), loop data at word 60
0 00 10000093
0 01 06400113
0 02 ff900193
0 03 00310233
0 04 402182b3
0 05 00411313
0 06 4011d393
0 07 0021d433
0 08 0021a4b3
0 09 0021b533
0 0a 003145b3
0 0b 0f05f613
0 0c 00566613
0 0d abcde6b7
0 0e 03710013
0 0f 0040a023
0 10 0050a223
0 11 0060a423
0 12 0070a623
0 13 0080a823
0 14 0090aa23
0 15 00a0ac23
0 16 00b0ae23
0 17 02c0a023
0 18 02d0a223
0 19 0200a423
0 1a 18000113
0 1b 00400193
0 1c 00000213
0 1d 00012283
0 1e 00520233
0 1f 00410113
0 20 fff18193
0 21 fe0198e3
0 22 00000463
0 23 3e820213
0 24 0240a623
0 25 00100073
0 4a deadbeef
0 60 00000011
0 61 00000022
0 62 00000033
0 63 00000044
2 00 00000000
3 00 00000000
1 40 0000005d
1 41 ffffff95
1 42 00000640
1 43 fffffffc
1 44 0fffffff
1 45 00000001
1 46 00000000
1 47 ffffff9d
1 48 00000095
1 49 abcde000
4 00 00000003
// test 4: x0 stored over a nonzero word
1 4a 00000000
4 00 00000004
// test 5: lw loop with bne and a taken beq
1 4b 000000aa
4 00 00000005
// test 6: add naming x17, the sw after it must not land
0 00 10000093
0 01 00088133
0 02 0210aa23
0 03 00100073
0 4d 5a5a5a5a
2 00 00000000
3 00 00000001
1 4d 5a5a5a5a
4 00 00000006
f 00 00000000

// File: bench/tb_rv32e_subsys.sv
// host-side testbench; reads bench/subsys_cases.txt, so it must be run from the project root
`timescale 1ns/10ps
`default_nettype none

module tb_rv32e_subsys
    import rv32e_pkg::*;
();

    localparam int MAX_RECORDS       = 128;
    localparam int CYCLES_PER_RECORD = 200;
    localparam int DRAIN_CYCLES      = 64;

    // record op codes of the case file
    localparam logic [31:0] OP_WRITE    = 32'h0;
    localparam logic [31:0] OP_READ     = 32'h1;
    localparam logic [31:0] OP_RUN      = 32'h2;
    localparam logic [31:0] OP_ILLEGAL  = 32'h3;
    localparam logic [31:0] OP_END_TEST = 32'h4;
    localparam logic [31:0] OP_STOP     = 32'hf;

    logic     clk;
    logic     rst;
    logic     host_req_valid;
    mem_req_t host_req;
    logic     host_req_credit;
    logic     host_rsp_valid;
    word_t    host_rsp_data;
    logic     host_rsp_credit;
    logic     run;
    logic     halted;
    logic     illegal;

    logic [31:0]           case_mem [3*MAX_RECORDS];
    int                    num_records;
    int                    host_credits;
    int                    req_sent;
    int                    credit_pulses;
    word_t                 exp_q [$];
    logic [MEM_AWIDTH-1:0] addr_q [$];
    logic [31:0]           last_addr;
    word_t                 last_data;
    int                    checks;
    int                    errors;
    int                    test_checks;
    int                    test_errors;
    int                    tests_done;

    always #5 clk = ~clk;

    rv32e_subsys rv32e_subsys_inst (
        .clk             (clk),
        .rst             (rst),
        .host_req_valid  (host_req_valid),
        .host_req        (host_req),
        .host_req_credit (host_req_credit),
        .host_rsp_valid  (host_rsp_valid),
        .host_rsp_data   (host_rsp_data),
        .host_rsp_credit (host_rsp_credit),
        .run             (run),
        .halted          (halted),
        .illegal         (illegal)
    );

    task automatic record_mismatch(input string msg);
        errors++;
        test_errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic note_problem(input string msg);
        errors++;
        test_errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // one clock of the host model, sampled at the falling edge
    task automatic step_cycle();
        word_t                 exp_word;
        logic [MEM_AWIDTH-1:0] exp_addr;
        @(negedge clk);
        if (host_req_credit) begin
            host_credits++;
            credit_pulses++;
            if (host_credits > HOST_CREDITS) begin
                note_problem("request credit returned with no request outstanding");
            end
        end
        host_rsp_credit = 1'b0;
        if (host_rsp_valid) begin
            // responses are consumed at once, credit goes straight back
            host_rsp_credit = 1'b1;
            if (exp_q.size() == 0) begin
                note_problem("read response arrived with no read outstanding");
            end else begin
                exp_word = exp_q.pop_front();
                exp_addr = addr_q.pop_front();
                checks++;
                test_checks++;
                if (host_rsp_data !== exp_word) begin
                    record_mismatch($sformatf("read of word %h returned %h, expected %h",
                                              exp_addr, host_rsp_data, exp_word));
                end
            end
        end
    endtask

    task automatic send_request(input logic we, input logic [31:0] addr, input word_t data);
        while (host_credits == 0) begin
            step_cycle();
        end
        host_req_valid = 1'b1;
        host_req.we    = we;
        host_req.addr  = addr[MEM_AWIDTH-1:0];
        host_req.wdata = data;
        host_credits--;
        req_sent++;
        step_cycle();
        host_req_valid = 1'b0;
    endtask

    // all credits home and every read answered, or give up after a while
    task automatic drain_host();
        int waited;
        waited = 0;
        while ((host_credits != HOST_CREDITS || exp_q.size() != 0) &&
               waited < DRAIN_CYCLES) begin
            step_cycle();
            waited++;
        end
    endtask

    // host reads of the last written word compete with the core while it runs,
    // so that word must not be a store target of the program
    task automatic run_program();
        drain_host();
        run = 1'b1;
        step_cycle();
        if (halted) begin
            note_problem("core stayed halted after run was raised");
        end
        while (!halted) begin
            exp_q.push_back(last_data);
            addr_q.push_back(last_addr[MEM_AWIDTH-1:0]);
            send_request(1'b0, last_addr, '0);
        end
        run = 1'b0;
    endtask

    task automatic close_test(input int id);
        drain_host();
        checks++;
        test_checks++;
        if (credit_pulses != req_sent) begin
            record_mismatch($sformatf("%0d credit pulses for %0d requests",
                                      credit_pulses, req_sent));
        end
        if (exp_q.size() != 0) begin
            note_problem($sformatf("%0d read responses never arrived", exp_q.size()));
            exp_q.delete();
            addr_q.delete();
        end
        $display("test %0d finished: %0d checks, %0d errors", id, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
        tests_done++;
    endtask

    // watchdog scaled by the number of case records
    initial begin
        wait (num_records > 0);
        repeat (num_records * CYCLES_PER_RECORD) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles",
                 num_records * CYCLES_PER_RECORD);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        clk             = 1'b0;
        rst             = 1'b1;
        host_req_valid  = 1'b0;
        host_req        = '0;
        host_rsp_credit = 1'b0;
        run             = 1'b0;
        host_credits    = HOST_CREDITS;
        req_sent        = 0;
        credit_pulses   = 0;
        last_addr       = '0;
        last_data       = '0;
        checks          = 0;
        errors          = 0;
        test_checks     = 0;
        test_errors     = 0;
        tests_done      = 0;
        num_records     = 0;

        $readmemh("bench/subsys_cases.txt", case_mem);
        while (num_records < MAX_RECORDS && case_mem[3*num_records] != OP_STOP) begin
            num_records++;
        end
        if (num_records == 0 || num_records == MAX_RECORDS) begin
            note_problem("case file is missing, empty or has no end record");
        end

        repeat (2) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < num_records && num_records < MAX_RECORDS; i++) begin
            op   = case_mem[3*i];
            addr = case_mem[3*i+1];
            data = case_mem[3*i+2];
            case (op)
                OP_WRITE: begin
                    last_addr = addr;
                    last_data = data;
                    send_request(1'b1, addr, data);
                end
                OP_READ: begin
                    exp_q.push_back(data);
                    addr_q.push_back(addr[MEM_AWIDTH-1:0]);
                    send_request(1'b0, addr, '0);
                end
                OP_RUN: run_program();
                OP_ILLEGAL: begin
                    checks++;
                    test_checks++;
                    if (halted !== 1'b1 || illegal !== data[0]) begin
                        record_mismatch($sformatf("halted %b illegal %b, expected 1 and %b",
                                                  halted, illegal, data[0]));
                    end
                end
                OP_END_TEST: close_test(data);
                default: note_problem($sformatf("record %0d has unknown op %h", i, op));
            endcase
        end
        drain_host();

        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
hdl/rv32e_pkg.sv
hdl/gpr_file.sv
hdl/alu.sv
hdl/core_ctrl.sv
hdl/credit_fifo.sv
hdl/mem_arbiter.sv
hdl/unified_mem.sv
hdl/rv32e_subsys.sv
bench/rv32e_subsys_chk.sv
bench/tb_rv32e_subsys.sv

// File: hdl/alu.sv
// RV32E integer unit; shifts use b[4:0] only
`timescale 1ns/10ps
`default_nettype none

module alu
    import rv32e_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   y,
    output logic    eq
);

    // branch compare
    assign eq = (a == b);

    always_comb begin
        case (op)
            ALU_ADD:    y = a + b;
            ALU_SUB:    y = a - b;
            ALU_SLL:    y = a << b[4:0];
            ALU_SLT:    y = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   y = {31'b0, a < b};
            ALU_XOR:    y = a ^ b;
            ALU_SRL:    y = a >> b[4:0];
            ALU_SRA:    y = word_t'($signed(a) >>> b[4:0]);
            ALU_OR:     y = a | b;
            ALU_AND:    y = a & b;
            ALU_PASS_B: y = b;
            default:    y = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/core_ctrl.sv
// multicycle RV32E subset core; word loads and stores only, pc bits above the memory range ignored
`timescale 1ns/10ps
`default_nettype none

module core_ctrl
    import rv32e_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     run,
    output logic     core_req_valid,
    output mem_req_t core_req,
    input  logic     core_gnt,
    input  word_t    mem_rdata,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output logic     rf_we,
    output word_t    rf_wdata,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output alu_op_t  alu_op,
    output word_t    alu_a,
    output word_t    alu_b,
    input  word_t    alu_y,
    input  logic     alu_eq,
    output logic     halted,
    output logic     illegal
);

    typedef enum logic [2:0] {S_IDLE, S_FETCH, S_WAIT, S_EXEC, S_MEM, S_MWAIT} state_t;

    state_t     state;
    word_t      pc;
    word_t      ir;
    word_t      ea;
    logic       run_q;
    logic [6:0] opc;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    logic       is_load;
    logic       is_store;
    logic       is_ebreak;
    logic       use_rs1;
    logic       use_rs2;
    logic       use_rd;
    logic       bad_fn;
    logic       bad_reg;
    logic       illegal_insn;

    assign opc    = ir[6:0];
    assign funct3 = ir[14:12];
    assign imm_i  = {{20{ir[31]}}, ir[31:20]};
    assign imm_s  = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b  = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u  = {ir[31:12], 12'h000};

    assign is_load   = (opc == OPC_LOAD);
    assign is_store  = (opc == OPC_STORE);
    assign is_ebreak = (ir == 32'h0010_0073);

    // register fields each format reads or writes
    assign use_rd  = opc inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_LOAD};
    assign use_rs1 = opc inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH};
    assign use_rs2 = opc inside {OPC_OP, OPC_STORE, OPC_BRANCH};

    // only beq/bne and word-sized memory ops
    assign bad_fn  = (opc == OPC_BRANCH && funct3[2:1] != 2'b00) ||
                     ((is_load || is_store) && funct3 != 3'b010);
    // x16 and up do not exist in RV32E
    assign bad_reg = (use_rd && ir[11]) || (use_rs1 && ir[19]) || (use_rs2 && ir[24]);
    assign illegal_insn = !(use_rs1 || opc == OPC_LUI || is_ebreak) || bad_fn || bad_reg;

    assign rs1 = ir[18:15];
    assign rs2 = ir[23:20];
    assign rd  = ir[10:7];

    always_comb begin
        alu_op = ALU_ADD;
        if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            case (funct3)
                3'd0:    alu_op = (opc == OPC_OP && ir[30]) ? ALU_SUB : ALU_ADD;
                3'd1:    alu_op = ALU_SLL;
                3'd2:    alu_op = ALU_SLT;
                3'd3:    alu_op = ALU_SLTU;
                3'd4:    alu_op = ALU_XOR;
                3'd5:    alu_op = ir[30] ? ALU_SRA : ALU_SRL;
                3'd6:    alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end else if (opc == OPC_LUI) begin
            alu_op = ALU_PASS_B;
        end
    end

    assign alu_a = rs1_data;
    assign alu_b = (opc == OPC_OP || opc == OPC_BRANCH) ? rs2_data :
                   (opc == OPC_LUI) ? imm_u :
                   is_store ? imm_s : imm_i;

    assign rf_we    = (state == S_EXEC && !illegal_insn && use_rd && !is_load) ||
                      (state == S_MWAIT && is_load);
    assign rf_wdata = (state == S_MWAIT) ? mem_rdata : alu_y;

    assign core_req_valid = (state == S_FETCH) || (state == S_MEM);
    assign core_req = '{
        we:    (state == S_MEM) && is_store,
        addr:  (state == S_MEM) ? ea[MEM_AWIDTH+1:2] : pc[MEM_AWIDTH+1:2],
        wdata: rs2_data
    };

    assign halted = (state == S_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            pc      <= '0;
            run_q   <= 1'b0;
            illegal <= 1'b0;
        end else begin
            run_q <= run;
            case (state)
                S_IDLE: if (run && !run_q) begin
                    pc      <= '0;
                    illegal <= 1'b0;
                    state   <= S_FETCH;
                end
                S_FETCH: if (core_gnt) state <= S_WAIT;
                S_WAIT: state <= S_EXEC;
                S_EXEC: begin
                    if (illegal_insn) begin
                        illegal <= 1'b1;
                        state   <= S_IDLE;
                    end else if (is_ebreak) begin
                        state <= S_IDLE;
                    end else if (is_load || is_store) begin
                        state <= S_MEM;
                    end else begin
                        // beq when equal, bne when not
                        pc    <= (opc == OPC_BRANCH && (alu_eq ^ funct3[0])) ? pc + imm_b
                                                                              : pc + 32'd4;
                        state <= S_FETCH;
                    end
                end
                S_MEM: if (core_gnt) state <= S_MWAIT;
                S_MWAIT: begin
                    pc    <= pc + 32'd4;
                    state <= S_FETCH;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // instruction and effective address latches
    always_ff @(posedge clk) begin
        if (state == S_WAIT) ir <= mem_rdata;
        if (state == S_EXEC) ea <= alu_y;
    end

endmodule

`default_nettype wire

// File: hdl/credit_fifo.sv
// host request buffer; the sender must hold a credit, so overflow is never checked
`timescale 1ns/10ps
`default_nettype none

module credit_fifo
    import rv32e_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  mem_req_t in_data,
    output logic     out_valid,
    output mem_req_t out_data,
    input  logic     out_take,
    output logic     credit
);

    mem_req_t              entries [HOST_CREDITS];
    logic [HOST_PTR_W-1:0] wr_ptr;
    logic [HOST_PTR_W-1:0] rd_ptr;
    logic [HOST_CNT_W-1:0] count;
    logic                  pop;

    assign out_valid = (count != '0);
    assign out_data  = entries[rd_ptr];
    assign pop       = out_take && out_valid;
    // one credit back per drained entry
    assign credit    = pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap naturally at the power-of-two depth
            if (in_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + HOST_CNT_W'(in_valid) - HOST_CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) entries[wr_ptr] <= in_data;
    end

endmodule

`default_nettype wire

// File: hdl/gpr_file.sv
// 16 x 32 register file, combinational reads, x0 hardwired to zero
`timescale 1ns/10ps
`default_nettype none

module gpr_file
    import rv32e_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     we,
    input  word_t    wdata,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    word_t regs [16];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // one-hot select per entry, reduced by OR
    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        for (int i = 0; i < 16; i++) begin
            rs1_data = rs1_data | ({32{rs1 == reg_idx_t'(i)}} & regs[i]);
            rs2_data = rs2_data | ({32{rs2 == reg_idx_t'(i)}} & regs[i]);
        end
    end

endmodule

`default_nettype wire

// File: hdl/mem_arbiter.sv
// round-robin host/core arbiter; the host must never return more response credits than it holds
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
    import rv32e_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     host_valid,
    input  mem_req_t host_req,
    output logic     host_take,
    input  logic     core_valid,
    input  mem_req_t core_req,
    output logic     core_gnt,
    input  logic     rsp_credit,
    output logic     host_rsp_valid,
    output logic     mem_req_valid,
    output mem_req_t mem_req
);

    logic [RSP_CNT_W-1:0] rsp_cnt;
    logic                 last_host;
    logic                 host_ok;
    logic                 spend;

    // host reads wait here until a response credit is free
    assign host_ok = host_valid && (host_req.we || rsp_cnt != '0);

    assign host_take = host_ok && (!core_valid || !last_host);
    assign core_gnt  = core_valid && !host_take;
    assign spend     = host_take && !host_req.we;

    assign mem_req_valid = host_take || core_gnt;
    assign mem_req       = host_take ? host_req : core_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_cnt        <= RSP_CNT_W'(RSP_CREDITS);
            last_host      <= 1'b0;
            host_rsp_valid <= 1'b0;
        end else begin
            rsp_cnt <= rsp_cnt + RSP_CNT_W'(rsp_credit) - RSP_CNT_W'(spend);
            if (mem_req_valid) last_host <= host_take;
            // read data shows up one cycle after the grant
            host_rsp_valid <= spend;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv32e_pkg.sv
// shared types for the RV32E subsystem; HOST_CREDITS must be a power of two
`default_nettype none

package rv32e_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    localparam int MEM_AWIDTH   = 8;
    localparam int HOST_CREDITS = 4;
    localparam int RSP_CREDITS  = 2;

    // derived counter and pointer widths
    localparam int HOST_PTR_W = $clog2(HOST_CREDITS);
    localparam int HOST_CNT_W = $clog2(HOST_CREDITS + 1);
    localparam int RSP_CNT_W  = $clog2(RSP_CREDITS + 1);

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    // word-addressed memory request, shared by host and core
    typedef struct packed {
        logic                  we;
        logic [MEM_AWIDTH-1:0] addr;
        word_t                 wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: hdl/rv32e_subsys.sv
// RV32E subsystem top; host holds HOST_CREDITS request credits and grants RSP_CREDITS at reset
`timescale 1ns/10ps
`default_nettype none

module rv32e_subsys
    import rv32e_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     host_req_valid,
    input  mem_req_t host_req,
    output logic     host_req_credit,
    output logic     host_rsp_valid,
    output word_t    host_rsp_data,
    input  logic     host_rsp_credit,
    input  logic     run,
    output logic     halted,
    output logic     illegal
);

    logic     fifo_valid;
    mem_req_t fifo_data;
    logic     host_take;
    logic     core_req_valid;
    mem_req_t core_req;
    logic     core_gnt;
    logic     mem_req_valid;
    mem_req_t mem_req;
    word_t    mem_rdata;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     rf_we;
    word_t    rf_wdata;
    word_t    rs1_data;
    word_t    rs2_data;
    alu_op_t  alu_op;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_y;
    logic     alu_eq;

    // memory read data is shared by host responses and the core
    assign host_rsp_data = mem_rdata;

    credit_fifo credit_fifo_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (host_req_valid),
        .in_data   (host_req),
        .out_valid (fifo_valid),
        .out_data  (fifo_data),
        .out_take  (host_take),
        .credit    (host_req_credit)
    );

    mem_arbiter mem_arbiter_inst (
        .clk            (clk),
        .rst            (rst),
        .host_valid     (fifo_valid),
        .host_req       (fifo_data),
        .host_take      (host_take),
        .core_valid     (core_req_valid),
        .core_req       (core_req),
        .core_gnt       (core_gnt),
        .rsp_credit     (host_rsp_credit),
        .host_rsp_valid (host_rsp_valid),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req)
    );

    unified_mem unified_mem_inst (
        .clk       (clk),
        .req_valid (mem_req_valid),
        .req       (mem_req),
        .rdata     (mem_rdata)
    );

    core_ctrl core_ctrl_inst (
        .clk            (clk),
        .rst            (rst),
        .run            (run),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_gnt       (core_gnt),
        .mem_rdata      (mem_rdata),
        .rs1            (rs1),
        .rs2            (rs2),
        .rd             (rd),
        .rf_we          (rf_we),
        .rf_wdata       (rf_wdata),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .alu_op         (alu_op),
        .alu_a          (alu_a),
        .alu_b          (alu_b),
        .alu_y          (alu_y),
        .alu_eq         (alu_eq),
        .halted         (halted),
        .illegal        (illegal)
    );

    alu alu_inst (
        .op (alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y),
        .eq (alu_eq)
    );

    gpr_file gpr_file_inst (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .we       (rf_we),
        .wdata    (rf_wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

`default_nettype wire

// File: hdl/unified_mem.sv
// single-port word memory, contents undefined until written
`timescale 1ns/10ps
`default_nettype none

module unified_mem
    import rv32e_pkg::*;
(
    input  logic     clk,
    input  logic     req_valid,
    input  mem_req_t req,
    output word_t    rdata
);

    word_t mem [2**MEM_AWIDTH];

    always_ff @(posedge clk) begin
        if (req_valid) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                // registered read, one cycle latency
                rdata <= mem[req.addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_rv32e_subsys \
        -f flist.f --Mdir obj_dir -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
